// File: common/astro_pkg.sv
// Astrocade board glue shared definitions
// Game codes, download indexes, joystick bit map, audio and matrix constants

package astro_pkg;

	// ==============================
	// Game selection
	// ==============================

	// Game code as sent in the download byte
	typedef enum logic [7:0] {
		game_none     = 8'd0,
		game_ebase    = 8'd1,
		game_seawolf2 = 8'd2,
		game_spacezap = 8'd3,
		game_gorf     = 8'd4,
		game_wow      = 8'd5,
		game_robby    = 8'd6,
		game_gorf1    = 8'd7
	} game_t;

	// Download index that carries the game code
	localparam logic [7:0] idx_game = 8'd1;

	// Download index that carries the DIP switch bytes
	localparam logic [7:0] idx_dip = 8'd254;

	// Number of DIP switch bytes held on the board
	localparam int dip_banks = 8;

	// ==============================
	// Joystick word layout
	// ==============================

	// Bit positions inside the 16-bit joystick word, active high
	localparam int joy_right  = 0;
	localparam int joy_left   = 1;
	localparam int joy_down   = 2;
	localparam int joy_up     = 3;
	localparam int joy_fire1  = 4;
	localparam int joy_fire2  = 5;
	localparam int joy_start1 = 6;
	localparam int joy_start2 = 7;

	// Coin only exists on the player 1 word
	localparam int joy_coin   = 8;

	// ==============================
	// Audio
	// ==============================

	// Unsigned sample width for chip, sample and output audio
	localparam int audio_w = 16;

	// Silence offset added to chip audio on the Gorf cabinet speaker
	// Chip silence is 0 while sample silence sits at mid scale
	localparam logic [audio_w:0] cab_offset = (audio_w + 1)'(16384);

	// ==============================
	// Switch matrix columns
	// ==============================

	// One-hot column strobes driven by the CPU
	localparam logic [7:0] col_p0  = 8'h01;
	localparam logic [7:0] col_p1  = 8'h02;
	localparam logic [7:0] col_p2  = 8'h04;

	// DIP column, answered with bank 3
	localparam logic [7:0] col_dip = 8'h08;

	// Idle row with no switch closed
	localparam logic [7:0] row_idle = 8'hff;

endpackage

// File: config/game_config.sv
// Game configuration block
// Takes the game code and DIP bytes from the byte-wide download port
// and decodes one flag per supported game

`timescale 1ns/1ps

module game_config (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        cfg_wr,
	input  logic [7:0]  cfg_index,
	input  logic [24:0] cfg_addr,
	input  logic [7:0]  cfg_data,
	output logic        is_spacezap,
	output logic        is_gorf,
	output logic        is_robby,
	output logic        gorf_prog1,
	output logic [7:0]  dip0,
	output logic [7:0]  dip2,
	output logic [7:0]  dip3
);
	import astro_pkg::*;

	localparam int bank_w = $clog2(dip_banks);

	game_t             game_code;
	logic [7:0]        dip_bank [dip_banks];
	logic              code_wr;
	logic              dip_wr;
	logic [bank_w-1:0] bank_sel;

	// Write decode on the download strobe
	assign code_wr  = cfg_wr && (cfg_index == idx_game);
	assign dip_wr   = cfg_wr && (cfg_index == idx_dip) && (cfg_addr < 25'(dip_banks));
	assign bank_sel = cfg_addr[bank_w-1:0];

	// ==============================
	// Code and DIP registers
	// ==============================

	// Game code, one cycle after the strobe
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game_code <= game_none;
		end else if (code_wr) begin
			game_code <= game_t'(cfg_data);
		end
	end

	// DIP switch bytes, addressed by the low download address
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < dip_banks; i++) begin
				dip_bank[i] <= '0;
			end
		end else if (dip_wr) begin
			dip_bank[bank_sel] <= cfg_data;
		end
	end

	// ==============================
	// Game flag decode
	// ==============================

	// Flags settle one cycle after the code register
	// Program 1 latches and keeps Gorf selected until reset
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			is_spacezap <= 1'b0;
			is_gorf     <= 1'b0;
			is_robby    <= 1'b0;
			gorf_prog1  <= 1'b0;
		end else begin
			is_spacezap <= (game_code == game_spacezap);
			is_robby    <= (game_code == game_robby);
			gorf_prog1  <= gorf_prog1 | (game_code == game_gorf1);
			is_gorf     <= (game_code == game_gorf) | (game_code == game_gorf1) | gorf_prog1;
		end
	end

	// Only the banks read by the matrix and mixer leave the block
	assign dip0 = dip_bank[0];
	assign dip2 = dip_bank[2];
	assign dip3 = dip_bank[3];

endmodule

// File: source/control_matrix.sv
// Switch matrix responder
// Answers the CPU column strobe with an active-low row byte
// built from joysticks, DIP bits and speech status per game

`timescale 1ns/1ps

module control_matrix (
	input  logic [7:0]  col_select,
	input  logic [15:0] joy_p1,
	input  logic [15:0] joy_p2,
	input  logic        speech_busy,
	input  logic        is_spacezap,
	input  logic        is_gorf,
	input  logic        is_robby,
	input  logic [7:0]  dip2,
	input  logic [7:0]  dip3,
	output logic [7:0]  row_data
);
	import astro_pkg::*;

	// Inverted fire1, right, left, down, up of one player
	function automatic logic [4:0] stick_nibble(input logic [15:0] joy);
		logic [4:0] pressed;
		pressed = {joy[joy_fire1], joy[joy_right], joy[joy_left], joy[joy_down], joy[joy_up]};
		return ~pressed;
	endfunction

	logic [4:0] p1_nib;
	logic [4:0] p2_nib;
	logic       start1_n;
	logic       start2_n;
	logic       coin_n;
	logic       any_game;

	logic [7:0] sz_p0;
	logic [7:0] sz_p1;
	logic [7:0] sz_p2;
	logic [7:0] gf_p0;
	logic [7:0] gf_p1;
	logic [7:0] gf_p2;
	logic [7:0] rr_p0;
	logic [7:0] rr_p1;
	logic [7:0] rr_p2;

	assign p1_nib = stick_nibble(joy_p1);
	assign p2_nib = stick_nibble(joy_p2);

	// Starts and coin always come from the player 1 word
	assign start1_n = ~joy_p1[joy_start1];
	assign start2_n = ~joy_p1[joy_start2];
	assign coin_n   = ~joy_p1[joy_coin];

	assign any_game = is_spacezap | is_gorf | is_robby;

	// ==============================
	// Per game row bytes
	// ==============================

	// Space Zap
	assign sz_p0 = {2'b11, start2_n, start1_n, dip2[1], 1'b1, coin_n, 1'b1};
	assign sz_p1 = {3'b111, p2_nib};
	assign sz_p2 = {2'b11, dip2[0], p1_nib};

	// Gorf, bit 7 of column 2 reads the speech busy line
	assign gf_p0 = {dip2[2], dip2[0], start2_n, start1_n, 1'b1, dip2[1], coin_n, 1'b1};
	assign gf_p1 = {3'b001, p2_nib};
	assign gf_p2 = {speech_busy, 2'b01, p1_nib};

	// Robby Roto, fire sits one bit above the stick
	assign rr_p0 = {1'b0, start2_n, start1_n, 1'b1, dip2[1], 1'b1, coin_n, 1'b1};
	assign rr_p1 = {2'b11, p2_nib[4], 1'b1, p2_nib[3:0]};
	assign rr_p2 = {2'b11, p1_nib[4], 1'b1, p1_nib[3:0]};

	// ==============================
	// Column select
	// ==============================

	// Zero latency, the CPU samples within its own read
	always_comb begin
		case (col_select)
			col_p0: begin
				row_data = is_spacezap ? sz_p0 : is_gorf ? gf_p0 : is_robby ? rr_p0 : row_idle;
			end
			col_p1: begin
				row_data = is_spacezap ? sz_p1 : is_gorf ? gf_p1 : is_robby ? rr_p1 : row_idle;
			end
			col_p2: begin
				row_data = is_spacezap ? sz_p2 : is_gorf ? gf_p2 : is_robby ? rr_p2 : row_idle;
			end
			// DIP bank 3 is shared by every kept game
			col_dip: begin
				row_data = any_game ? dip3 : row_idle;
			end
			default: begin
				row_data = row_idle;
			end
		endcase
	end

endmodule

// File: audio/audio_mixer.sv
// Audio mixer
// Picks chip or sample audio per game, applies the Gorf cabinet
// speaker routing and the channel swap, registered output

`timescale 1ns/1ps

module audio_mixer (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          is_spacezap,
	input  logic                          is_gorf,
	input  logic                          is_robby,
	input  logic [7:0]                    dip0,
	input  logic                          speech_select,
	input  logic [astro_pkg::audio_w-1:0] chip_l,
	input  logic [astro_pkg::audio_w-1:0] chip_r,
	input  logic [astro_pkg::audio_w-1:0] samp_l,
	input  logic [astro_pkg::audio_w-1:0] samp_r,
	output logic [astro_pkg::audio_w-1:0] audio_l,
	output logic [astro_pkg::audio_w-1:0] audio_r
);
	import astro_pkg::*;

	logic [audio_w-1:0] work_l;
	logic [audio_w-1:0] work_r;
	logic [audio_w:0]   cab_sum;
	logic [audio_w-1:0] cab_l;
	logic [audio_w-1:0] speech_l;
	logic [audio_w-1:0] mix_l;
	logic [audio_w-1:0] mix_r;
	logic               cabinet;
	logic               swap;

	// Halved chip plus halved sample, two 15-bit values never clip
	assign work_l = {1'b0, chip_l[audio_w-1:1]} + {1'b0, samp_l[audio_w-1:1]};
	assign work_r = {1'b0, chip_r[audio_w-1:1]} + {1'b0, samp_r[audio_w-1:1]};

	// Lower cabinet speaker, chip lifted to sample silence level
	assign cab_sum  = {1'b0, chip_l} + cab_offset;
	assign cab_l    = cab_sum[audio_w] ? '1 : cab_sum[audio_w-1:0];
	assign speech_l = {1'b0, samp_l[audio_w-1:1]};

	// DIP bank 0 bit 0 selects cabinet wiring, bit 1 swaps channels
	assign cabinet = dip0[0];
	assign swap    = dip0[1];

	// ==============================
	// Per game selection
	// ==============================

	always_comb begin
		if (is_spacezap) begin
			// Single chip, mono
			mix_l = chip_l;
			mix_r = chip_l;
		end else if (is_gorf) begin
			if (cabinet) begin
				// Top speaker one chip, lower speaker chip or speech
				mix_r = chip_r;
				mix_l = speech_select ? speech_l : cab_l;
			end else begin
				mix_l = work_l;
				mix_r = work_r;
			end
		end else if (is_robby) begin
			// Two chips, true stereo
			mix_l = chip_l;
			mix_r = chip_r;
		end else begin
			mix_l = chip_l;
			mix_r = chip_l;
		end
	end

	// Output register with the channel swap
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= swap ? mix_r : mix_l;
			audio_r <= swap ? mix_l : mix_r;
		end
	end

endmodule

// File: source/lamp_serializer.sv
// Gorf rank lamp serializer
// Sends each changed lamp bit to an external addressable latch,
// one write pulse per bit, paced by a free running divider

`timescale 1ns/1ps

module lamp_serializer #(
	parameter int lamp_count = 8,
	parameter int pace_div   = 4
) (
	input  logic                          clk_sys,
	input  logic                          reset,
	input  logic                          enable,
	input  logic [lamp_count-1:0]         lamp_request,
	output logic [$clog2(lamp_count)-1:0] lamp_addr,
	output logic                          lamp_data,
	output logic                          lamp_write_n
);
	localparam int addr_w = $clog2(lamp_count);
	localparam int cnt_w  = (pace_div > 1) ? $clog2(pace_div) : 1;

	logic [cnt_w-1:0]      pace_cnt;
	logic                  pace_tick;
	logic [lamp_count-1:0] shadow;
	logic [lamp_count-1:0] diff;
	logic [addr_w-1:0]     first_sel;
	logic                  issue;

	// Pace divider, one tick every pace_div cycles
	assign pace_tick = (pace_cnt == cnt_w'(pace_div - 1));

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			pace_cnt <= '0;
		end else if (pace_tick) begin
			pace_cnt <= '0;
		end else begin
			pace_cnt <= pace_cnt + 1'b1;
		end
	end

	// Bits whose latch state differs from the request
	assign diff = shadow ^ lamp_request;

	// Lowest changed bit wins, scan from the top down
	always_comb begin
		first_sel = '0;
		for (int i = lamp_count - 1; i >= 0; i--) begin
			if (diff[i]) begin
				first_sel = addr_w'(i);
			end
		end
	end

	// New write only on a tick with the strobe already released
	assign issue = pace_tick && lamp_write_n && enable && (|diff);

	// Strobe and shadow of the latch contents
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			lamp_write_n <= 1'b1;
			shadow       <= '1;
		end else if (pace_tick && !lamp_write_n) begin
			lamp_write_n <= 1'b1;
		end else if (issue) begin
			lamp_write_n      <= 1'b0;
			shadow[first_sel] <= lamp_request[first_sel];
		end
	end

	// Address and data held through the low strobe
	always_ff @(posedge clk_sys) begin
		if (issue) begin
			lamp_addr <= first_sel;
			lamp_data <= lamp_request[first_sel];
		end
	end

endmodule

// File: source/astro_board_io.sv
// Astrocade board glue top level
// Game configuration, switch matrix, audio mixer and Gorf lamp output
// around an external CPU and custom chip set

`timescale 1ns/1ps

module astro_board_io #(
	parameter int lamp_count = 8,
	parameter int pace_div   = 4
) (
	input  logic                          clk_sys,
	input  logic                          reset,
	// Download port
	input  logic                          cfg_wr,
	input  logic [7:0]                    cfg_index,
	input  logic [24:0]                   cfg_addr,
	input  logic [7:0]                    cfg_data,
	// Switch matrix
	input  logic [7:0]                    col_select,
	output logic [7:0]                    row_data,
	input  logic [15:0]                   joy_p1,
	input  logic [15:0]                   joy_p2,
	input  logic                          speech_busy,
	// Audio
	input  logic                          speech_select,
	input  logic [astro_pkg::audio_w-1:0] chip_l,
	input  logic [astro_pkg::audio_w-1:0] chip_r,
	input  logic [astro_pkg::audio_w-1:0] samp_l,
	input  logic [astro_pkg::audio_w-1:0] samp_r,
	output logic [astro_pkg::audio_w-1:0] audio_l,
	output logic [astro_pkg::audio_w-1:0] audio_r,
	// Rank lamps
	input  logic [lamp_count-1:0]         lamp_request,
	output logic [$clog2(lamp_count)-1:0] lamp_addr,
	output logic                          lamp_data,
	output logic                          lamp_write_n,
	output logic                          gorf_prog1
);

	logic       is_spacezap;
	logic       is_gorf;
	logic       is_robby;
	logic [7:0] dip0;
	logic [7:0] dip2;
	logic [7:0] dip3;

	game_config u_game_config (
		.clk_sys(clk_sys), .reset(reset),
		.cfg_wr(cfg_wr), .cfg_index(cfg_index), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
		.is_spacezap(is_spacezap), .is_gorf(is_gorf), .is_robby(is_robby),
		.gorf_prog1(gorf_prog1), .dip0(dip0), .dip2(dip2), .dip3(dip3)
	);

	control_matrix u_control_matrix (
		.col_select(col_select), .joy_p1(joy_p1), .joy_p2(joy_p2),
		.speech_busy(speech_busy), .is_spacezap(is_spacezap), .is_gorf(is_gorf),
		.is_robby(is_robby), .dip2(dip2), .dip3(dip3), .row_data(row_data)
	);

	audio_mixer u_audio_mixer (
		.clk_sys(clk_sys), .reset(reset),
		.is_spacezap(is_spacezap), .is_gorf(is_gorf), .is_robby(is_robby),
		.dip0(dip0), .speech_select(speech_select),
		.chip_l(chip_l), .chip_r(chip_r), .samp_l(samp_l), .samp_r(samp_r),
		.audio_l(audio_l), .audio_r(audio_r)
	);

	// Lamps only run on a Gorf cabinet
	lamp_serializer #(.lamp_count(lamp_count), .pace_div(pace_div)) u_lamp_serializer (
		.clk_sys(clk_sys), .reset(reset), .enable(is_gorf),
		.lamp_request(lamp_request), .lamp_addr(lamp_addr),
		.lamp_data(lamp_data), .lamp_write_n(lamp_write_n)
	);

endmodule

// File: sim/tb_astro_board_io.sv
// Testbench for the Astrocade board glue
// Table of game setups applied in a loop against the switch matrix and mixer,
// then lamp serializer runs and reset state checks

`timescale 1ns/1ps

module tb_astro_board_io;
	import astro_pkg::*;

	localparam int lamp_count = 8;
	localparam int pace_div   = 4;

	// One table row, stimulus followed by expected responses
	typedef struct packed {
		logic [7:0]  game;
		logic [7:0]  dip0;
		logic [7:0]  dip2;
		logic [7:0]  dip3;
		logic [7:0]  col;
		logic        sbusy;
		logic        ssel;
		logic [15:0] joy1;
		logic [15:0] joy2;
		logic [15:0] chip_l;
		logic [15:0] chip_r;
		logic [15:0] samp_l;
		logic [15:0] samp_r;
		logic [7:0]  exp_row;
		logic [15:0] exp_l;
		logic [15:0] exp_r;
	} case_t;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        cfg_wr;
	logic [7:0]  cfg_index;
	logic [24:0] cfg_addr;
	logic [7:0]  cfg_data;
	logic [7:0]  col_select;
	logic [7:0]  row_data;
	logic [15:0] joy_p1;
	logic [15:0] joy_p2;
	logic        speech_busy;
	logic        speech_select;
	logic [15:0] chip_l;
	logic [15:0] chip_r;
	logic [15:0] samp_l;
	logic [15:0] samp_r;
	logic [15:0] audio_l;
	logic [15:0] audio_r;
	logic [7:0]  lamp_request;
	logic [2:0]  lamp_addr;
	logic        lamp_data;
	logic        lamp_write_n;
	logic        gorf_prog1;

	case_t       cases [$];
	logic [31:0] lfsr_state;

	astro_board_io #(.lamp_count(lamp_count), .pace_div(pace_div)) uut (.*);

	// 100 MHz system clock
	always #5 clk_sys = ~clk_sys;

	// ==============================
	// Random source and checking
	// ==============================

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "Testbench stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			stop_with_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
		end
	endtask

	// ==============================
	// Reference model
	// ==============================

	// Fire1, right, left, down, up as seen on the row, active low
	function automatic logic [4:0] player_bits(input logic [15:0] j);
		return ~{j[joy_fire1], j[joy_right], j[joy_left], j[joy_down], j[joy_up]};
	endfunction

	function automatic logic [7:0] expect_row(input case_t c);
		logic [4:0] n1;
		logic [4:0] n2;
		logic [2:0] sc;
		n1 = player_bits(c.joy1);
		n2 = player_bits(c.joy2);
		// Start2, start1 and coin, always from player 1
		sc = ~{c.joy1[joy_start2], c.joy1[joy_start1], c.joy1[joy_coin]};
		if (c.game == game_gorf || c.game == game_gorf1) begin
			case (c.col)
				col_p0:  return {c.dip2[2], c.dip2[0], sc[2], sc[1], 1'b1, c.dip2[1], sc[0], 1'b1};
				col_p1:  return {3'b001, n2};
				col_p2:  return {c.sbusy, 2'b01, n1};
				col_dip: return c.dip3;
				default: return 8'hff;
			endcase
		end else if (c.game == game_spacezap) begin
			case (c.col)
				col_p0:  return {2'b11, sc[2], sc[1], c.dip2[1], 1'b1, sc[0], 1'b1};
				col_p1:  return {3'b111, n2};
				col_p2:  return {2'b11, c.dip2[0], n1};
				col_dip: return c.dip3;
				default: return 8'hff;
			endcase
		end else if (c.game == game_robby) begin
			// Fire moved up one bit, bit 4 idle high
			case (c.col)
				col_p0:  return {1'b0, sc[2], sc[1], 1'b1, c.dip2[1], 1'b1, sc[0], 1'b1};
				col_p1:  return {2'b11, n2[4], 1'b1, n2[3:0]};
				col_p2:  return {2'b11, n1[4], 1'b1, n1[3:0]};
				col_dip: return c.dip3;
				default: return 8'hff;
			endcase
		end
		return 8'hff;
	endfunction

	// Left in the upper half, right in the lower half
	function automatic logic [31:0] expect_audio(input case_t c);
		logic [16:0] lifted;
		logic [15:0] l;
		logic [15:0] r;
		l = c.chip_l;
		r = c.chip_l;
		lifted = {1'b0, c.chip_l} + 17'd16384;
		if (c.game == game_robby) begin
			r = c.chip_r;
		end else if (c.game == game_gorf || c.game == game_gorf1) begin
			if (c.dip0[0]) begin
				// Cabinet wiring, lower speaker clips at full scale
				r = c.chip_r;
				l = c.ssel ? (c.samp_l >> 1) : (lifted[16] ? 16'hffff : lifted[15:0]);
			end else begin
				l = (c.chip_l >> 1) + (c.samp_l >> 1);
				r = (c.chip_r >> 1) + (c.samp_r >> 1);
			end
			if (c.dip0[1]) begin
				return {r, l};
			end
		end
		return {l, r};
	endfunction

	task automatic add_case(input logic [7:0] game, input logic [7:0] dip0,
		input logic [7:0] dip2, input logic [7:0] col,
		input logic sbusy, input logic ssel, input logic hi);
		case_t       c;
		logic [31:0] r;
		c = '0;
		c.game  = game;
		c.dip0  = dip0;
		c.dip2  = dip2;
		c.col   = col;
		c.sbusy = sbusy;
		c.ssel  = ssel;
		take_bits(8, r);
		c.dip3 = r[7:0];
		take_bits(9, r);
		c.joy1 = {7'd0, r[8:0]};
		take_bits(5, r);
		c.joy2 = {11'd0, r[4:0]};
		take_bits(16, r);
		c.chip_l = r[15:0];
		take_bits(16, r);
		c.chip_r = r[15:0];
		take_bits(16, r);
		c.samp_l = r[15:0];
		take_bits(16, r);
		c.samp_r = r[15:0];
		// Push chip audio into the clipping range
		if (hi) begin
			c.chip_l[15:14] = 2'b11;
		end
		c.exp_row = expect_row(c);
		{c.exp_l, c.exp_r} = expect_audio(c);
		cases.push_back(c);
	endtask

	// ==============================
	// Bus drivers
	// ==============================

	task automatic write_download(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		@(posedge clk_sys);
		cfg_wr    <= 1'b1;
		cfg_index <= index;
		cfg_addr  <= addr;
		cfg_data  <= data;
		@(posedge clk_sys);
		cfg_wr <= 1'b0;
	endtask

	task automatic load_config(input case_t c);
		write_download(idx_game, 25'd0, c.game);
		// Filler in every bank first
		for (int b = 0; b < dip_banks; b++) begin
			write_download(idx_dip, 25'(b), 8'h50 | 8'(b));
		end
		write_download(idx_dip, 25'd0, c.dip0);
		write_download(idx_dip, 25'd2, c.dip2);
		write_download(idx_dip, 25'd3, c.dip3);
		// Out of range and foreign index, all ignored
		write_download(idx_dip, 25'd8, ~c.dip0);
		write_download(idx_dip, 25'h100003, ~c.dip3);
		write_download(8'd2, 25'd0, 8'd5);
		// Flags settle two cycles after the code strobe
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic check_idle();
		check_value("row_data", 32'(row_data), 32'hff);
		check_value("audio_l", 32'(audio_l), 32'h0);
		check_value("audio_r", 32'(audio_r), 32'h0);
		check_value("lamp_write_n", 32'(lamp_write_n), 32'h1);
	endtask

	task automatic apply_reset();
		@(posedge clk_sys);
		reset         <= 1'b1;
		cfg_wr        <= 1'b0;
		joy_p1        <= '0;
		joy_p2        <= '0;
		speech_busy   <= 1'b0;
		speech_select <= 1'b0;
		chip_l        <= '0;
		chip_r        <= '0;
		samp_l        <= '0;
		samp_r        <= '0;
		lamp_request  <= '1;
		// Three cycles in reset, one column per cycle
		for (int n = 0; n < 3; n++) begin
			col_select <= 8'h01 << n;
			@(negedge clk_sys);
			check_idle();
			@(posedge clk_sys);
		end
		reset <= 1'b0;
		// No game loaded, all columns idle
		for (int n = 0; n < 5; n++) begin
			@(posedge clk_sys);
			col_select <= 8'h01 << n;
			@(negedge clk_sys);
			check_idle();
		end
	endtask

	// Changed bits must come out lowest first, one pulse each
	task automatic drive_lamps(input logic [7:0] old_req, input logic [7:0] new_req);
		logic [2:0] want [$];
		int         seen;
		int         waited;
		logic       prev;
		for (int b = 0; b < lamp_count; b++) begin
			if (old_req[b] != new_req[b]) begin
				want.push_back(3'(b));
			end
		end
		@(posedge clk_sys);
		lamp_request <= new_req;
		seen   = 0;
		waited = 0;
		prev   = 1'b1;
		while (seen < want.size()) begin
			@(negedge clk_sys);
			waited++;
			if (waited > 40 * pace_div) begin
				stop_with_failure("Timed out waiting for lamp write pulses");
			end
			if (prev && !lamp_write_n) begin
				check_value("lamp_addr", 32'(lamp_addr), 32'(want[seen]));
				check_value("lamp_data", 32'(lamp_data), 32'(new_req[want[seen]]));
				seen++;
			end
			prev = lamp_write_n;
		end
		// Quiet for a few pace ticks
		for (int q = 0; q < 4 * pace_div; q++) begin
			@(negedge clk_sys);
			if (prev && !lamp_write_n) begin
				stop_with_failure("Extra lamp write pulse after all changed bits");
			end
			prev = lamp_write_n;
		end
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		case_t       c;
		logic [31:0] r;
		logic [7:0]  first_req;
		logic [7:0]  next_req;
		lfsr_state    = 32'h11e9;
		reset         = 1'b1;
		cfg_wr        = 1'b0;
		cfg_index     = '0;
		cfg_addr      = '0;
		cfg_data      = '0;
		col_select    = '0;
		joy_p1        = '0;
		joy_p2        = '0;
		speech_busy   = 1'b0;
		speech_select = 1'b0;
		chip_l        = '0;
		chip_r        = '0;
		samp_l        = '0;
		samp_r        = '0;
		lamp_request  = '1;

		add_case(game_spacezap, 8'h00, 8'h03, col_p0, 1'b0, 1'b0, 1'b0);
		add_case(game_spacezap, 8'h00, 8'h02, col_p1, 1'b0, 1'b0, 1'b0);
		add_case(game_spacezap, 8'h00, 8'h01, col_p2, 1'b0, 1'b0, 1'b0);
		add_case(game_spacezap, 8'h00, 8'h00, col_dip, 1'b0, 1'b0, 1'b0);
		add_case(game_spacezap, 8'h00, 8'h00, 8'h10, 1'b0, 1'b0, 1'b0);
		add_case(game_robby, 8'h00, 8'h02, col_p0, 1'b0, 1'b0, 1'b0);
		add_case(game_robby, 8'h00, 8'h00, col_p1, 1'b0, 1'b0, 1'b0);
		add_case(game_robby, 8'h00, 8'h05, col_p2, 1'b0, 1'b0, 1'b0);
		add_case(game_robby, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0);
		add_case(game_none, 8'h00, 8'h07, col_p0, 1'b0, 1'b0, 1'b0);
		add_case(game_none, 8'h00, 8'h00, col_dip, 1'b0, 1'b0, 1'b0);
		add_case(game_gorf, 8'h00, 8'h05, col_p0, 1'b0, 1'b0, 1'b0);
		add_case(game_gorf, 8'h00, 8'h02, col_p0, 1'b0, 1'b0, 1'b0);
		add_case(game_gorf, 8'h00, 8'h00, col_p1, 1'b0, 1'b0, 1'b0);
		add_case(game_gorf, 8'h00, 8'h00, col_p2, 1'b1, 1'b0, 1'b0);
		add_case(game_gorf, 8'h00, 8'h00, col_dip, 1'b0, 1'b0, 1'b0);
		// Cabinet routing, clipping and channel swap
		add_case(game_gorf, 8'h01, 8'h00, col_p0, 1'b0, 1'b1, 1'b0);
		add_case(game_gorf, 8'h01, 8'h00, col_p2, 1'b0, 1'b0, 1'b1);
		add_case(game_gorf, 8'h01, 8'h00, col_p1, 1'b0, 1'b0, 1'b0);
		add_case(game_gorf, 8'h02, 8'h00, col_p1, 1'b0, 1'b0, 1'b0);
		add_case(game_gorf, 8'h03, 8'h00, col_p2, 1'b1, 1'b1, 1'b0);
		add_case(game_gorf, 8'h03, 8'h00, col_p0, 1'b0, 1'b0, 1'b1);
		add_case(game_gorf1, 8'h00, 8'h07, col_p0, 1'b0, 1'b0, 1'b0);
		add_case(game_gorf1, 8'h01, 8'h00, col_p2, 1'b1, 1'b0, 1'b1);

		for (int i = 0; i < cases.size(); i++) begin
			c = cases[i];
			apply_reset();
			load_config(c);
			col_select    <= c.col;
			joy_p1        <= c.joy1;
			joy_p2        <= c.joy2;
			speech_busy   <= c.sbusy;
			speech_select <= c.ssel;
			chip_l        <= c.chip_l;
			chip_r        <= c.chip_r;
			samp_l        <= c.samp_l;
			samp_r        <= c.samp_r;
			// Mixer output lands one cycle later
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_value("row_data", 32'(row_data), 32'(c.exp_row));
			if (c.game != game_none) begin
				check_value("audio_l", 32'(audio_l), 32'(c.exp_l));
				check_value("audio_r", 32'(audio_r), 32'(c.exp_r));
			end
			check_value("gorf_prog1", 32'(gorf_prog1), 32'(c.game == game_gorf1));
		end

		// Gorf lamps, two rounds of changes
		apply_reset();
		write_download(idx_game, 25'd0, game_gorf);
		repeat (4) @(posedge clk_sys);
		take_bits(8, r);
		first_req = (r[7:0] == 8'hff) ? 8'h5a : r[7:0];
		drive_lamps(8'hff, first_req);
		take_bits(8, r);
		next_req = (r[7:0] == first_req) ? ~first_req : r[7:0];
		drive_lamps(first_req, next_req);

		// Space Zap leaves the lamp latch alone, request differs from the reset shadow
		apply_reset();
		write_download(idx_game, 25'd0, game_spacezap);
		repeat (4) @(posedge clk_sys);
		lamp_request <= first_req;
		for (int q = 0; q < 25 * pace_div; q++) begin
			@(negedge clk_sys);
			check_value("lamp_write_n", 32'(lamp_write_n), 32'h1);
		end

		$display("ALL TESTS PASSED");
		$finish;
	end

	// Whole run limit
	initial begin
		#1000000;
		stop_with_failure("Simulation watchdog expired before the test sequence ended");
	end

endmodule

// File: sim.f
common/astro_pkg.sv
config/game_config.sv
source/control_matrix.sv
audio/audio_mixer.sv
source/lamp_serializer.sv
source/astro_board_io.sv
sim/tb_astro_board_io.sv

// File: Makefile
# Verilator build and run of the board glue testbench

TOP     := tb_astro_board_io
SOURCES := $(shell cat sim.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/V$(TOP): sim.f $(SOURCES)
	verilator --binary --timing -j 0 --top-module $(TOP) -f sim.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
